// File: logic/lsPkg.sv
// load/store cluster types: data and tag widths, opcodes, broadcast, issue and result records
package lsPkg;

    localparam int dataW = 32;
    localparam int slotW = 4;
    localparam int nameW = 5;

    typedef logic [dataW-1:0] dataT;
    // top bit is the unit prefix, low bits the slot index
    typedef logic [slotW:0] tagT;
    typedef logic [nameW-1:0] nameT;

    localparam tagT tagFree = '0;
    localparam logic lsPrefix = 1'b1;

    typedef enum logic [1:0] {
        opNop   = 2'd0,
        opLoad  = 2'd1,
        opStore = 2'd2
    } lsOpT;

    typedef struct packed {
        logic valid;
        tagT  tag;
        dataT data;
    } cdbT;

    typedef struct packed {
        lsOpT op;
        dataT operandO;
        tagT  tagO;
        dataT operandT;
        // tag of operandT
        tagT  tagTwo;
        dataT imm;
        tagT  tagW;
        nameT nameW;
    } dispatchT;

    typedef struct packed {
        logic valid;
        lsOpT op;
        dataT operandO;
        dataT operandT;
        dataT imm;
        tagT  tagW;
        nameT nameW;
    } issueT;

    typedef struct packed {
        cdbT  cdb;
        nameT nameW;
        logic isStore;
    } resultT;

endpackage

// File: logic/dataMemory.sv
// data memory: single-port word RAM with registered read and a clearing sweep after reset
module dataMemory #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [$clog2(memWords)-1:0] addr,
    input  lsPkg::dataT                 wdata,
    input  logic                        we,
    input  logic                        re,
    output lsPkg::dataT                 rdata,
    output logic                        busy
);
    import lsPkg::*;

    localparam int addrBits = $clog2(memWords);

    typedef logic [addrBits-1:0] addrT;

    dataT mem [memWords];
    addrT sweepAddr;
    logic sweeping;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping <= 1'b1;
            sweepAddr <= '0;
        end else if (sweeping) begin
            sweepAddr <= sweepAddr + 1'b1;
            if (sweepAddr == addrT'(memWords - 1)) begin
                sweeping <= 1'b0;
            end
        end
    end

    // sweep owns the port until every word is zero
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweepAddr] <= '0;
        end else if (we) begin
            mem[addr] <= wdata;
        end
        if (re && !sweeping) begin
            rdata <= mem[addr];
        end
    end

    assign busy = sweeping;

endmodule

// File: logic/loadStoreUnit.sv
// load/store unit: address stage, memory access stage, result held until the bus grants it
module loadStoreUnit #(
    parameter int memWords = 256
) (
    input  logic                        clk,
    input  logic                        rst,
    input  lsPkg::issueT                issue,
    input  logic                        cdbGrant,
    input  logic                        memBusy,
    input  lsPkg::dataT                 memRdata,
    output logic                        unitReady,
    output logic [$clog2(memWords)-1:0] memAddr,
    output lsPkg::dataT                 memWdata,
    output logic                        memWe,
    output logic                        memRe,
    output lsPkg::resultT               result,
    output lsPkg::cdbT                  lsCdb
);
    import lsPkg::*;

    localparam int addrBits = $clog2(memWords);

    typedef logic [addrBits-1:0] addrT;

    // stage 1, address formed
    logic s1Valid;
    lsOpT s1Op;
    addrT s1Addr;
    dataT s1Data;
    tagT  s1Tag;
    nameT s1Name;

    // stage 2, result waiting for the bus
    logic s2Valid;
    logic s2Store;
    tagT  s2Tag;
    nameT s2Name;

    logic s1Free;
    logic s2Free;
    logic s1Adv;
    logic take;

    assign s2Free = !s2Valid || cdbGrant;
    assign s1Free = !s1Valid || s2Free;
    assign s1Adv = s1Valid && s2Free;
    assign unitReady = s1Free && !memBusy;
    assign take = issue.valid && unitReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            if (s1Free) begin
                s1Valid <= take;
            end
            if (s2Free) begin
                s2Valid <= s1Valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            s1Op <= issue.op;
            // word index wraps at the memory depth
            s1Addr <= addrT'(issue.operandO + issue.imm);
            s1Data <= issue.operandT;
            s1Tag <= issue.tagW;
            s1Name <= issue.nameW;
        end
        if (s1Adv) begin
            s2Store <= s1Op == opStore;
            s2Tag <= s1Tag;
            s2Name <= s1Name;
        end
    end

    // access fires only on the edge that moves stage 1 forward
    assign memAddr = s1Addr;
    assign memWdata = s1Data;
    assign memWe = s1Adv && s1Op == opStore;
    assign memRe = s1Adv && s1Op == opLoad;

    // read data sits in the memory's output register and holds while stage 2 stalls
    always_comb begin
        result.cdb.valid = s2Valid;
        result.cdb.tag = s2Tag;
        result.cdb.data = s2Store ? '0 : memRdata;
        result.nameW = s2Name;
        result.isStore = s2Store;
        lsCdb = result.cdb;
        lsCdb.valid = s2Valid && cdbGrant;
    end

endmodule

// File: logic/lsReservation.sv
// load/store reservation station: holds memory ops, wakes operands from both broadcasts, issues
module lsReservation #(
    parameter int rsSize = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  lsPkg::dispatchT   dispatch,
    input  lsPkg::cdbT        aluCdb,
    input  lsPkg::cdbT        lsCdb,
    input  logic              unitReady,
    output lsPkg::issueT      issue,
    output logic [rsSize-1:0] freeSlots
);
    import lsPkg::*;

    localparam int idxBits = $clog2(rsSize);

    // one source operand, value plus pending tag
    typedef struct packed {
        tagT  tag;
        dataT data;
    } opndT;

    lsOpT slotOp   [rsSize];
    opndT slotO    [rsSize];
    opndT slotT    [rsSize];
    dataT slotImm  [rsSize];
    nameT slotName [rsSize];

    opndT wakeO [rsSize];
    opndT wakeT [rsSize];
    opndT dispO;
    opndT dispT;

    logic [rsSize-1:0]  occupied;
    logic [rsSize-1:0]  readyVec;
    logic [rsSize-1:0]  pickVec;
    logic [idxBits-1:0] pickIdx;
    logic [idxBits-1:0] dispIdx;
    logic               dispValid;
    logic               issueGo;

    // replace a pending tag with broadcast data, ALU broadcast checked first
    function automatic opndT snoop(opndT cur, cdbT alu, cdbT ls);
        opndT res;
        res = cur;
        if (cur.tag != tagFree) begin
            if (alu.valid && alu.tag == cur.tag) begin
                res.tag = tagFree;
                res.data = alu.data;
            end else if (ls.valid && ls.tag == cur.tag) begin
                res.tag = tagFree;
                res.data = ls.data;
            end
        end
        return res;
    endfunction

    always_comb begin
        for (int i = 0; i < rsSize; i++) begin
            occupied[i] = slotOp[i] != opNop;
            readyVec[i] = occupied[i] && slotO[i].tag == tagFree && slotT[i].tag == tagFree;
            wakeO[i] = snoop(slotO[i], aluCdb, lsCdb);
            wakeT[i] = snoop(slotT[i], aluCdb, lsCdb);
        end
    end

    // incoming operands see this cycle's broadcasts too
    always_comb begin
        dispO = snoop({dispatch.tagO, dispatch.operandO}, aluCdb, lsCdb);
        dispT = snoop({dispatch.tagTwo, dispatch.operandT}, aluCdb, lsCdb);
    end

    assign dispValid = dispatch.op != opNop;
    assign dispIdx = dispatch.tagW[idxBits-1:0];
    assign freeSlots = ~occupied;

    // lowest ready slot as one-hot, then its index
    assign pickVec = readyVec & -readyVec;

    always_comb begin
        pickIdx = '0;
        for (int i = 0; i < rsSize; i++) begin
            if (pickVec[i]) begin
                pickIdx = idxBits'(i);
            end
        end
    end

    assign issueGo = unitReady && |readyVec;

    // slot occupancy and the issue register
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rsSize; i++) begin
                slotOp[i] <= opNop;
            end
            issue.valid <= 1'b0;
        end else begin
            // issue register holds while the unit is not ready
            if (unitReady) begin
                issue.valid <= issueGo;
            end
            if (issueGo) begin
                slotOp[pickIdx] <= opNop;
                issue.op <= slotOp[pickIdx];
                issue.operandO <= slotO[pickIdx].data;
                issue.operandT <= slotT[pickIdx].data;
                issue.imm <= slotImm[pickIdx];
                issue.tagW <= {lsPrefix, slotW'(pickIdx)};
                issue.nameW <= slotName[pickIdx];
            end
            if (dispValid) begin
                slotOp[dispIdx] <= dispatch.op;
            end
        end
    end

    // operand wakeup and dispatch writes
    always_ff @(posedge clk) begin
        for (int i = 0; i < rsSize; i++) begin
            slotO[i] <= wakeO[i];
            slotT[i] <= wakeT[i];
        end
        if (dispValid) begin
            slotO[dispIdx] <= dispO;
            slotT[dispIdx] <= dispT;
            slotImm[dispIdx] <= dispatch.imm;
            slotName[dispIdx] <= dispatch.nameW;
        end
    end

endmodule

// File: logic/lsCluster.sv
// load/store cluster top: reservation station feeding the load/store unit and its data memory
module lsCluster #(
    parameter int rsSize   = 8,
    parameter int memWords = 256
) (
    input  logic              clk,
    input  logic              rst,
    input  lsPkg::dispatchT   dispatch,
    input  lsPkg::cdbT        aluCdb,
    input  logic              cdbGrant,
    output logic [rsSize-1:0] freeSlots,
    output lsPkg::resultT     lsResult,
    output logic              memReady
);
    import lsPkg::*;

    localparam int addrBits = $clog2(memWords);

    issueT               issue;
    logic                unitReady;
    cdbT                 lsCdb;
    logic [addrBits-1:0] memAddr;
    dataT                memWdata;
    dataT                memRdata;
    logic                memWe;
    logic                memRe;
    logic                memBusy;

    lsReservation #(
        .rsSize(rsSize)
    ) u_lsReservation (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .aluCdb   (aluCdb),
        .lsCdb    (lsCdb),
        .unitReady(unitReady),
        .issue    (issue),
        .freeSlots(freeSlots)
    );

    loadStoreUnit #(
        .memWords(memWords)
    ) u_loadStoreUnit (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .cdbGrant (cdbGrant),
        .memBusy  (memBusy),
        .memRdata (memRdata),
        .unitReady(unitReady),
        .memAddr  (memAddr),
        .memWdata (memWdata),
        .memWe    (memWe),
        .memRe    (memRe),
        .result   (lsResult),
        .lsCdb    (lsCdb)
    );

    dataMemory #(
        .memWords(memWords)
    ) u_dataMemory (
        .clk  (clk),
        .rst  (rst),
        .addr (memAddr),
        .wdata(memWdata),
        .we   (memWe),
        .re   (memRe),
        .rdata(memRdata),
        .busy (memBusy)
    );

    assign memReady = !memBusy;

endmodule

// File: verification/lsClusterTb.sv
// testbench for the load/store cluster with random memory traffic checked against a cycle model
module lsClusterTb;
    timeunit 1ns;
    timeprecision 100ps;

    import lsPkg::*;

    localparam int rsSize = 8;
    localparam int memWords = 256;
    localparam int stimCycles = 40 + 120 + 150 + 150 + 200 + 4 * 7;
    localparam int cycleLimit = 4 * stimCycles + 2000;
    localparam int drainLimit = 300;

    typedef struct packed {
        tagT  tag;
        dataT data;
    } opndT;

    logic              clk;
    logic              rst;
    dispatchT          dispatch;
    cdbT               aluCdb;
    logic              cdbGrant;
    logic [rsSize-1:0] freeSlots;
    resultT            lsResult;
    logic              memReady;

    integer seed;
    int errors;
    int cycleCount;
    int sentCount;
    int resultCount;
    int totalResults;
    int testCount;
    int testErrStart;
    int sweepCycles;

    // model of slots, issue register, two unit stages and memory
    lsOpT mOp   [rsSize];
    opndT mO    [rsSize];
    opndT mT    [rsSize];
    dataT mImm  [rsSize];
    nameT mName [rsSize];
    logic iValid;
    lsOpT iOp;
    dataT iO;
    dataT iT;
    dataT iImm;
    tagT  iTag;
    nameT iName;
    logic s1V;
    lsOpT s1Op;
    int   s1Addr;
    dataT s1Data;
    tagT  s1Tag;
    nameT s1Name;
    logic s2V;
    logic s2Store;
    tagT  s2Tag;
    nameT s2Name;
    dataT s2Data;
    dataT mem [memWords];
    // ALU tags still owed a broadcast
    logic [15:0] aluPend;
    dataT aluVal [16];

    lsCluster #(
        .rsSize  (rsSize),
        .memWords(memWords)
    ) u_lsCluster (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .aluCdb   (aluCdb),
        .cdbGrant (cdbGrant),
        .freeSlots(freeSlots),
        .lsResult (lsResult),
        .memReady (memReady)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // stops a run that outlives its stimulus
    initial begin
        wait (cycleCount > cycleLimit);
        $display("run stopped at the cycle limit of %0d", cycleLimit);
        $display("Simulation failed");
        $finish;
    end

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic opndT resolve(opndT cur, cdbT alu, cdbT ls);
        opndT res;
        res = cur;
        if (cur.tag != tagFree && alu.valid && alu.tag == cur.tag) begin
            res.tag = tagFree;
            res.data = alu.data;
        end else if (cur.tag != tagFree && ls.valid && ls.tag == cur.tag) begin
            res.tag = tagFree;
            res.data = ls.data;
        end
        return res;
    endfunction

    function automatic logic modelIdle();
        logic idle;
        idle = !iValid && !s1V && !s2V;
        for (int i = 0; i < rsSize; i++) begin
            idle = idle && mOp[i] == opNop;
        end
        return idle;
    endfunction

    task automatic resetModel();
        for (int i = 0; i < rsSize; i++) begin
            mOp[i] = opNop;
        end
        for (int a = 0; a < memWords; a++) begin
            mem[a] = '0;
        end
        iValid = 1'b0;
        s1V = 1'b0;
        s2V = 1'b0;
        aluPend = '0;
    endtask

    // one rising edge of the cluster
    task automatic stepModel(dispatchT d, cdbT alu, logic grant);
        cdbT  lsB;
        logic s2Free;
        logic unitRdy;
        int   pick;
        int   slot;
        dataT sum;
        lsB.valid = s2V && grant;
        lsB.tag = s2Tag;
        lsB.data = s2Data;
        s2Free = !s2V || grant;
        unitRdy = !s1V || s2Free;
        if (s2Free) begin
            if (s1V) begin
                s2Store = s1Op == opStore;
                s2Tag = s1Tag;
                s2Name = s1Name;
                if (s2Store) begin
                    mem[s1Addr] = s1Data;
                    s2Data = '0;
                end else begin
                    s2Data = mem[s1Addr];
                end
            end
            s2V = s1V;
        end
        if (unitRdy) begin
            if (iValid) begin
                sum = iO + iImm;
                s1Op = iOp;
                s1Addr = sum % memWords;
                s1Data = iT;
                s1Tag = iTag;
                s1Name = iName;
            end
            s1V = iValid;
            pick = -1;
            for (int i = rsSize - 1; i >= 0; i--) begin
                if (mOp[i] != opNop && mO[i].tag == tagFree && mT[i].tag == tagFree) begin
                    pick = i;
                end
            end
            iValid = pick >= 0;
            if (pick >= 0) begin
                iOp = mOp[pick];
                iO = mO[pick].data;
                iT = mT[pick].data;
                iImm = mImm[pick];
                iTag = {lsPrefix, slotW'(pick)};
                iName = mName[pick];
                mOp[pick] = opNop;
            end
        end
        for (int i = 0; i < rsSize; i++) begin
            mO[i] = resolve(mO[i], alu, lsB);
            mT[i] = resolve(mT[i], alu, lsB);
        end
        if (d.op != opNop) begin
            slot = int'(d.tagW[slotW-1:0]);
            mOp[slot] = d.op;
            mO[slot] = resolve({d.tagO, d.operandO}, alu, lsB);
            mT[slot] = resolve({d.tagTwo, d.operandT}, alu, lsB);
            mImm[slot] = d.imm;
            mName[slot] = d.nameW;
        end
    endtask

    task automatic reportErr(string sig, dataT expV, dataT got);
        $display("ERR %s expected %h got %h", sig, expV, got);
        errors++;
    endtask

    task automatic compareOutputs();
        logic [rsSize-1:0] expFree;
        for (int i = 0; i < rsSize; i++) begin
            expFree[i] = mOp[i] == opNop;
        end
        if (freeSlots !== expFree) begin
            reportErr("freeSlots", dataT'(expFree), dataT'(freeSlots));
        end
        if (lsResult.cdb.valid !== s2V) begin
            reportErr("lsResult.cdb.valid", dataT'(s2V), dataT'(lsResult.cdb.valid));
        end else if (s2V) begin
            if (lsResult.cdb.tag !== s2Tag) begin
                reportErr("lsResult.cdb.tag", dataT'(s2Tag), dataT'(lsResult.cdb.tag));
            end
            if (lsResult.cdb.data !== s2Data) begin
                reportErr("lsResult.cdb.data", s2Data, lsResult.cdb.data);
            end
            if (lsResult.nameW !== s2Name) begin
                reportErr("lsResult.nameW", dataT'(s2Name), dataT'(lsResult.nameW));
            end
            if (lsResult.isStore !== s2Store) begin
                reportErr("lsResult.isStore", dataT'(s2Store), dataT'(lsResult.isStore));
            end
        end
    endtask

    // inputs are already driven, so advance to the next falling edge and check
    task automatic cycleEnd();
        if (lsResult.cdb.valid === 1'b1 && cdbGrant) begin
            resultCount++;
        end
        stepModel(dispatch, aluCdb, cdbGrant);
        cycleCount++;
        @(negedge clk);
        compareOutputs();
    endtask

    function automatic int randomSlot(logic wantFree);
        int cand[$];
        for (int i = 0; i < rsSize; i++) begin
            if ((mOp[i] == opNop) == wantFree) begin
                cand.push_back(i);
            end
        end
        if (cand.size() == 0) begin
            return -1;
        end
        return cand[rnd(cand.size())];
    endfunction

    // value, pending ALU tag, or tag of a waiting load/store slot
    function automatic opndT makeOperand(int pAlu, int pLs, dataT value);
        opndT o;
        int   t;
        int   s;
        o.tag = tagFree;
        o.data = value;
        if (rnd(100) < pAlu) begin
            t = 1 + rnd(15);
            if (!aluPend[t]) begin
                aluPend[t] = 1'b1;
                aluVal[t] = value;
            end
            o.tag = tagT'(t);
            o.data = dataT'($random(seed));
        end else if (rnd(100) < pLs) begin
            s = randomSlot(1'b0);
            if (s >= 0) begin
                o.tag = {lsPrefix, slotW'(s)};
                o.data = dataT'($random(seed));
            end
        end
        return o;
    endfunction

    function automatic cdbT pickBroadcast(int pBcast);
        cdbT c;
        int  t;
        c = '0;
        if (|aluPend && rnd(100) < pBcast) begin
            t = 1 + rnd(15);
            while (!aluPend[t]) begin
                t = (t % 15) + 1;
            end
            aluPend[t] = 1'b0;
            c.valid = 1'b1;
            c.tag = tagT'(t);
            c.data = aluVal[t];
        end
        return c;
    endfunction

    task automatic drain();
        int waited;
        waited = 0;
        dispatch = '0;
        cdbGrant = 1'b1;
        while (!modelIdle() || freeSlots !== '1 || lsResult.cdb.valid !== 1'b0) begin
            if (waited == drainLimit) begin
                $display("pipeline did not drain within %0d cycles", drainLimit);
                errors++;
                break;
            end
            aluCdb = pickBroadcast(100);
            waited++;
            cycleEnd();
        end
        aluCdb = '0;
    endtask

    task automatic startTest();
        testErrStart = errors;
        sentCount = 0;
        resultCount = 0;
    endtask

    task automatic endTest(string name);
        int errs;
        drain();
        if (resultCount != sentCount) begin
            $display("test %s: %0d instructions dispatched but %0d results granted",
                     name, sentCount, resultCount);
            errors++;
        end
        errs = errors - testErrStart;
        totalResults += resultCount;
        testCount++;
        $display("test %s done: %0d results, %0d errors", name, resultCount, errs);
    endtask

    task automatic runTraffic(int cycles, int pStore, int pAlu, int pLs, int pGrant,
                              dataT addrMask, dataT immMask);
        int   slot;
        opndT base;
        opndT sdat;
        for (int c = 0; c < cycles; c++) begin
            dispatch = '0;
            slot = randomSlot(1'b1);
            if (slot >= 0 && rnd(100) < 70) begin
                base = makeOperand(pAlu, pLs, dataT'($random(seed)) & addrMask);
                sdat = makeOperand(pAlu, pLs, dataT'($random(seed)));
                dispatch.op = (rnd(100) < pStore) ? opStore : opLoad;
                dispatch.operandO = base.data;
                dispatch.tagO = base.tag;
                dispatch.operandT = sdat.data;
                dispatch.tagTwo = sdat.tag;
                dispatch.imm = dataT'($random(seed)) & immMask;
                dispatch.tagW = {lsPrefix, slotW'(slot)};
                dispatch.nameW = nameT'(rnd(32));
                sentCount++;
            end
            aluCdb = pickBroadcast(40);
            cdbGrant = rnd(100) < pGrant;
            cycleEnd();
        end
    endtask

    // six slots wait on one ALU tag, then wake together
    task automatic issueOrder(int rounds);
        int slot;
        int t;
        for (int r = 0; r < rounds; r++) begin
            aluPend = '0;
            t = 1 + rnd(15);
            aluPend[t] = 1'b1;
            aluVal[t] = dataT'($random(seed)) & 32'h3f;
            aluCdb = '0;
            cdbGrant = 1'b1;
            for (int k = 0; k < 6; k++) begin
                slot = randomSlot(1'b1);
                dispatch = '0;
                dispatch.op = (rnd(2) == 0) ? opStore : opLoad;
                dispatch.operandO = dataT'($random(seed));
                dispatch.tagO = tagT'(t);
                dispatch.operandT = dataT'($random(seed));
                dispatch.imm = dataT'(k);
                dispatch.tagW = {lsPrefix, slotW'(slot)};
                dispatch.nameW = nameT'(rnd(32));
                sentCount++;
                cycleEnd();
            end
            dispatch = '0;
            aluCdb = pickBroadcast(100);
            cycleEnd();
            drain();
        end
    endtask

    initial begin
        seed = 32'hce214e57;
        errors = 0;
        cycleCount = 0;
        totalResults = 0;
        testCount = 0;
        sweepCycles = 0;
        rst = 1'b1;
        dispatch = '0;
        aluCdb = '0;
        cdbGrant = 1'b0;
        resetModel();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (memReady !== 1'b1) begin
            sweepCycles++;
            cycleEnd();
        end

        startTest();
        if (sweepCycles != memWords) begin
            $display("memory sweep took %0d cycles instead of %0d", sweepCycles, memWords);
            errors++;
        end
        if (freeSlots !== '1) begin
            reportErr("freeSlots", dataT'({rsSize{1'b1}}), dataT'(freeSlots));
        end
        if (lsResult.cdb.valid !== 1'b0) begin
            reportErr("lsResult.cdb.valid", '0, dataT'(lsResult.cdb.valid));
        end
        runTraffic(40, 0, 0, 0, 100, 32'hff, 32'h0);
        endTest("resetState");

        startTest();
        runTraffic(120, 50, 0, 0, 100, 32'h7, 32'h3);
        endTest("storeLoad");

        startTest();
        runTraffic(150, 40, 60, 0, 100, 32'h1f, 32'h3);
        endTest("wakeup");

        startTest();
        runTraffic(150, 30, 20, 60, 100, 32'h1f, 32'h3);
        endTest("selfForward");

        startTest();
        runTraffic(200, 40, 30, 30, 50, 32'hff, 32'hffffffff);
        endTest("backPressure");

        startTest();
        issueOrder(4);
        endTest("issueOrder");

        $display("summary: %0d tests, %0d results, %0d cycles, %0d errors",
                 testCount, totalResults, cycleCount, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
logic/lsPkg.sv
logic/dataMemory.sv
logic/loadStoreUnit.sv
logic/lsReservation.sv
logic/lsCluster.sv
verification/lsClusterTb.sv

// File: Makefile
# Verilator build for the load/store cluster testbench

VERILATOR ?= verilator
TOP       ?= lsClusterTb
RTL_TOP   ?= lsCluster
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "failure reported in $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Simulation passed" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
